/* list.f */
+incdir+testbench
rtl/core_pkg.sv
rtl/cp0_pkg.sv
rtl/exception_unit.sv
rtl/cp0_regs.sv
rtl/pc_redirect.sv
rtl/cp0_subsystem.sv
testbench/cp0_subsystem_checker.sv
testbench/cp0_subsystem_tb.sv

/* testbench/cp0_model.svh */
`ifndef CP0_MODEL_SVH
`define CP0_MODEL_SVH

// ############################################################################
// Reference model of the CP0 state, timer and fetch redirect
// ############################################################################

cp0_regs_t m_cp0;
logic      m_toggle;
logic      m_timer;
redirect_t m_redirect;

function automatic word_t expected_read(input logic [4:0] addr);
    case (addr)
        5'd8:    return m_cp0.badvaddr;
        5'd9:    return m_cp0.count;
        5'd11:   return m_cp0.compare;
        5'd12:   return m_cp0.status;
        5'd13:   return m_cp0.cause;
        5'd14:   return m_cp0.epc;
        5'd16:   return m_cp0.config_;
        default: return 32'd0;
    endcase
endfunction

task automatic reset_model();
    m_cp0          = '0;
    m_cp0.config_  = 32'h8000_0000;
    m_toggle       = 1'b1;
    m_timer        = 1'b0;
    m_redirect     = '0;
endtask

// Advances the model by one clock edge with the inputs seen at that edge
task automatic advance_model(input retire_lane_t [1:0] lanes, input logic [5:0] hw);
    cp0_regs_t nxt;
    logic      pend;
    logic      exc;
    logic      eret;
    logic      cmp_wr;
    logic [4:0] code;
    int        win;
    nxt = m_cp0;
    nxt.count = m_cp0.count + m_toggle;
    nxt.cause.ip[7:2] = {m_timer | hw[5], hw[4:0]};
    pend = m_cp0.status.ie && !m_cp0.status.exl && |(m_cp0.status.im & m_cp0.cause.ip);
    win = 2;
    exc = 1'b0;
    eret = 1'b0;
    cmp_wr = 1'b0;
    code = 5'd0;
    for (int i = 0; i < 2; i++) begin
        if (win == 2 && lanes[i].valid) begin
            if (i == 0 && pend) begin
                win = 0;
                exc = 1'b1;
                code = 5'd0;
            end else if (lanes[i].exc_valid) begin
                win = i;
                exc = 1'b1;
                code = lanes[i].exc_code;
            end else if (lanes[i].is_eret) begin
                win = i;
                eret = 1'b1;
            end
        end
    end
    for (int i = 0; i < win; i++) begin  // Only lanes older than the winner write
        if (lanes[i].valid && lanes[i].cp0write) begin
            case (lanes[i].dst)
                5'd9:  nxt.count = lanes[i].data;
                5'd11: begin
                    nxt.compare = lanes[i].data;
                    cmp_wr = 1'b1;
                end
                5'd12: begin
                    nxt.status.im  = lanes[i].data[15:8];
                    nxt.status.exl = lanes[i].data[1];
                    nxt.status.ie  = lanes[i].data[0];
                end
                5'd13: nxt.cause.ip[1:0] = lanes[i].data[9:8];
                5'd14: nxt.epc = lanes[i].data;
                default: ;
            endcase
        end
    end
    if (exc) begin
        if (!m_cp0.status.exl) begin
            nxt.cause.bd = lanes[win].in_delay_slot;
            nxt.epc = lanes[win].in_delay_slot ? lanes[win].pc - 32'd4 : lanes[win].pc;
        end
        nxt.cause.exccode = code;
        nxt.status.exl = 1'b1;
        if (code == 5'd4 || code == 5'd5) nxt.badvaddr = lanes[win].badvaddr;
    end
    if (eret) begin
        if (m_cp0.status.erl) nxt.status.erl = 1'b0;
        else nxt.status.exl = 1'b0;
    end
    if (nxt.count == nxt.compare) m_timer = 1'b1;
    else if (cmp_wr) m_timer = 1'b0;
    m_redirect.valid = exc | eret;
    if (exc) m_redirect.pc = 32'hBFC0_0380;
    else if (eret) m_redirect.pc = m_cp0.epc;
    m_cp0 = nxt;
    m_toggle = ~m_toggle;
endtask

`endif

/* testbench/cp0_subsystem_tb.sv */
`timescale 1ns/1ps

module cp0_subsystem_tb;
    import core_pkg::*;
    import cp0_pkg::*;

    logic                   clk;
    logic                   resetn;
    retire_lane_t [1:0]     retire;
    logic [5:0]             hw_int;
    creg_addr_t [1:0]       read_addr;
    word_t [1:0]            read_data;
    redirect_t              redirect;
    logic                   timer_interrupt;

    logic [31:0] rng = 32'd32573;
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;
    logic        timed_out;

    `include "cp0_model.svh"

    cp0_subsystem cp0_subsystem_inst (
        .clk             (clk),
        .resetn          (resetn),
        .retire          (retire),
        .hw_int          (hw_int),
        .read_addr       (read_addr),
        .read_data       (read_data),
        .redirect        (redirect),
        .timer_interrupt (timer_interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Mostly real registers and sometimes an unmapped number
    function logic [4:0] pick_reg();
        logic [31:0] r;
        r = next_rand();
        case (r % 8)
            0: return 5'd8;
            1: return 5'd9;
            2: return 5'd11;
            3: return 5'd12;
            4: return 5'd13;
            5: return 5'd14;
            6: return 5'd16;
            default: return r[12:8];
        endcase
    endfunction

    task automatic make_lane(output retire_lane_t l, input int p_exc, input int p_eret,
                             input int p_wr);
        logic [31:0] r;
        logic [4:0]  codes [7] = '{5'd0, 5'd4, 5'd5, 5'd8, 5'd9, 5'd10, 5'd12};
        r = next_rand();
        l = '0;
        l.valid         = (r % 4) != 0;
        l.in_delay_slot = r[20];
        l.pc            = next_rand() & 32'hFFFF_FFFC;
        l.cp0write      = (next_rand() % 100) < p_wr;
        l.dst           = pick_reg();
        l.data          = next_rand();
        l.exc_valid     = (next_rand() % 100) < p_exc;
        l.exc_code      = codes[next_rand() % 7];
        l.is_eret       = !l.exc_valid && ((next_rand() % 100) < p_eret);
        l.badvaddr      = next_rand();
    endtask

    task automatic check_outputs(input string name);
        word_t exp;
        for (int p = 0; p < 2; p++) begin
            exp = expected_read(read_addr[p]);
            if (read_data[p] !== exp) begin
                $display("Error %s: read port %0d reg %0d expected %h actual %h",
                         name, p, read_addr[p], exp, read_data[p]);
                test_errors++;
            end
        end
        if (redirect.valid !== m_redirect.valid) begin
            $display("Error %s: redirect.valid expected %b actual %b",
                     name, m_redirect.valid, redirect.valid);
            test_errors++;
        end else if (m_redirect.valid && redirect.pc !== m_redirect.pc) begin
            $display("Error %s: redirect.pc expected %h actual %h",
                     name, m_redirect.pc, redirect.pc);
            test_errors++;
        end
        if (timer_interrupt !== m_timer) begin
            $display("Error %s: timer_interrupt expected %b actual %b",
                     name, m_timer, timer_interrupt);
            test_errors++;
        end
    endtask

    // Returns 1 ns after the edge, which is where the next inputs are driven
    task automatic step(input string name);
        @(posedge clk);
        advance_model(retire, hw_int);
        #1;
        check_outputs(name);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors != 0) tests_failed++;
        total_errors += test_errors;
        $display("Test %s done with %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    task automatic run_random(input string name, input int cycles, input int p_exc,
                              input int p_eret, input int p_wr, input int p_hw);
        logic [31:0] r;
        for (int n = 0; n < cycles; n++) begin
            make_lane(retire[0], p_exc, p_eret, p_wr);
            make_lane(retire[1], p_exc, p_eret, p_wr);
            if (m_redirect.valid) retire = '0;  // Keep redirects one cycle apart
            r = next_rand();
            hw_int = ((r % 100) < p_hw) ? r[13:8] : 6'd0;
            read_addr[0] = pick_reg();
            read_addr[1] = pick_reg();
            step(name);
        end
        finish_test(name);
    endtask

    // Lane 0 stays idle so a pending interrupt cannot swallow the write
    task automatic write_lane1(input logic [4:0] dst, input word_t data, input string name);
        retire = '0;
        retire[1].valid    = 1'b1;
        retire[1].cp0write = 1'b1;
        retire[1].dst      = dst;
        retire[1].data     = data;
        step(name);
        retire = '0;
    endtask

    task automatic timer_test();
        int waited;
        hw_int = '0;
        read_addr[0] = CREG_CAUSE;
        read_addr[1] = CREG_COUNT;
        write_lane1(CREG_STATUS, 32'd0, "timer");
        write_lane1(CREG_COMPARE, m_cp0.count + 32'd3 + (next_rand() % 6), "timer");
        waited = 0;
        while (timer_interrupt !== 1'b1 && waited < 40) begin
            step("timer");
            waited++;
        end
        if (timer_interrupt !== 1'b1) begin
            $display("Timeout: timer_interrupt never rose after the Compare write");
            timed_out = 1'b1;
            test_errors++;
        end
        step("timer");  // IP[7] follows one edge later
        write_lane1(CREG_COMPARE, m_cp0.count + 32'd1000, "timer");
        waited = 0;
        while (timer_interrupt !== 1'b0 && waited < 4) begin
            step("timer");
            waited++;
        end
        if (timer_interrupt !== 1'b0) begin
            $display("Timeout: timer_interrupt did not clear after a new Compare write");
            timed_out = 1'b1;
            test_errors++;
        end
        finish_test("timer");
    endtask

    initial begin
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        resetn       = 1'b0;
        retire       = '0;
        hw_int       = '0;
        read_addr    = '0;
        reset_model();
        repeat (16) @(posedge clk);
        #1;
        resetn = 1'b1;

        // ####################################################################
        // Test sequence
        // ####################################################################
        run_random("write_read", 60, 0, 0, 90, 0);
        timer_test();
        run_random("exceptions", 80, 30, 0, 40, 0);
        run_random("eret", 60, 15, 30, 40, 0);
        run_random("lane_masking", 80, 20, 20, 90, 0);
        run_random("interrupts", 120, 5, 15, 60, 70);

        $display("Tests run %0d, failed %0d, errors %0d, timeouts %0d",
                 tests_run, tests_failed, total_errors, timed_out);
        if (total_errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* testbench/cp0_subsystem_checker.sv */
`timescale 1ns/1ps

module cp0_subsystem_checker (
    input logic clk,
    input logic resetn,
    input logic redirect_valid,
    input logic exc_valid,
    input logic is_eret,
    input logic timer_interrupt
);

    // ########################################################################
    // Redirect pulse rules
    // ########################################################################

    redirect_single_cycle: assert property (
        @(posedge clk) disable iff (!resetn) redirect_valid |=> !redirect_valid
    ) else $error("redirect.valid held for two cycles");

    redirect_has_cause: assert property (
        @(posedge clk) disable iff (!resetn) redirect_valid |-> $past(exc_valid | is_eret)
    ) else $error("redirect.valid without a preceding exception or ERET");

    // Outputs are still at their reset values on the first edge out of reset
    quiet_after_reset: assert property (
        @(posedge clk) $rose(resetn) |-> (!redirect_valid && !timer_interrupt)
    ) else $error("redirect or timer interrupt set right after reset");

endmodule

bind cp0_subsystem cp0_subsystem_checker cp0_subsystem_checker_inst (
    .clk             (clk),
    .resetn          (resetn),
    .redirect_valid  (redirect.valid),
    .exc_valid       (exception.valid),
    .is_eret         (is_eret),
    .timer_interrupt (timer_interrupt)
);

/* rtl/cp0_subsystem.sv */
`timescale 1ns/1ps

module cp0_subsystem #(
    parameter int ISSUE_WIDTH = 2,
    parameter int READ_PORTS  = 2
) (
    input  logic                                     clk,
    input  logic                                     resetn,
    input  core_pkg::retire_lane_t [ISSUE_WIDTH-1:0] retire,
    input  logic [5:0]                               hw_int,
    input  cp0_pkg::creg_addr_t [READ_PORTS-1:0]     read_addr,
    output core_pkg::word_t [READ_PORTS-1:0]         read_data,
    output core_pkg::redirect_t                      redirect,
    output logic                                     timer_interrupt
);
    import core_pkg::*;
    import cp0_pkg::*;

    status_t                         status;
    cause_t                          cause;
    word_t                           epc;
    exception_t                      exception;
    logic                            is_eret;
    retire_lane_t [ISSUE_WIDTH-1:0]  masked_retire;

    // ########################################################################
    // Exception selection, register state and fetch redirect
    // ########################################################################

    exception_unit #(
        .ISSUE_WIDTH(ISSUE_WIDTH)
    ) exception_unit_inst (
        .retire        (retire),
        .status        (status),
        .cause         (cause),
        .exception     (exception),
        .is_eret       (is_eret),
        .masked_retire (masked_retire)
    );

    cp0_regs #(
        .ISSUE_WIDTH(ISSUE_WIDTH),
        .READ_PORTS (READ_PORTS)
    ) cp0_regs_inst (
        .clk             (clk),
        .resetn          (resetn),
        .masked_retire   (masked_retire),
        .exception       (exception),
        .is_eret         (is_eret),
        .hw_int          (hw_int),
        .read_addr       (read_addr),
        .read_data       (read_data),
        .status          (status),
        .cause           (cause),
        .epc             (epc),
        .timer_interrupt (timer_interrupt)
    );

    pc_redirect pc_redirect_inst (
        .clk       (clk),
        .resetn    (resetn),
        .exception (exception),
        .is_eret   (is_eret),
        .epc       (epc),
        .redirect  (redirect)
    );

endmodule

/* rtl/pc_redirect.sv */
`timescale 1ns/1ps

module pc_redirect (
    input  logic                 clk,
    input  logic                 resetn,
    input  core_pkg::exception_t exception,
    input  logic                 is_eret,
    input  core_pkg::word_t      epc,
    output core_pkg::redirect_t  redirect
);
    import core_pkg::*;

    logic  redirect_valid;
    word_t redirect_pc;

    // A single cycle pulse follows every exception or ERET
    always_ff @(posedge clk) begin
        if (!resetn) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= exception.valid | is_eret;
        end
    end

    // EPC is taken before the edge so an ERET returns to the old value
    always_ff @(posedge clk) begin
        if (exception.valid) begin
            redirect_pc <= EXC_VECTOR;
        end else if (is_eret) begin
            redirect_pc <= epc;
        end
    end

    assign redirect.valid = redirect_valid;
    assign redirect.pc    = redirect_pc;

endmodule

/* rtl/cp0_regs.sv */
`timescale 1ns/1ps

module cp0_regs #(
    parameter int ISSUE_WIDTH = 2,
    parameter int READ_PORTS  = 2
) (
    input  logic                                     clk,
    input  logic                                     resetn,
    input  core_pkg::retire_lane_t [ISSUE_WIDTH-1:0] masked_retire,
    input  core_pkg::exception_t                     exception,
    input  logic                                     is_eret,
    input  logic [5:0]                               hw_int,
    input  cp0_pkg::creg_addr_t [READ_PORTS-1:0]     read_addr,
    output core_pkg::word_t [READ_PORTS-1:0]         read_data,
    output cp0_pkg::status_t                         status,
    output cp0_pkg::cause_t                          cause,
    output core_pkg::word_t                          epc,
    output logic                                     timer_interrupt
);
    import cp0_pkg::*;

    cp0_regs_t  cp0;
    cp0_regs_t  cp0_new;
    logic       count_toggle;   // Count moves on every second edge
    logic       compare_write;
    cp0_wdata_u wdata;

    // ########################################################################
    // State
    // ########################################################################

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cp0 <= CP0_INIT;
        end else begin
            cp0 <= cp0_new;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            count_toggle <= 1'b1;
        end else begin
            count_toggle <= ~count_toggle;
        end
    end

    // A match wins over a Compare write landing on the same edge
    always_ff @(posedge clk) begin
        if (!resetn) begin
            timer_interrupt <= 1'b0;
        end else if (cp0_new.count == cp0_new.compare) begin
            timer_interrupt <= 1'b1;
        end else if (compare_write) begin
            timer_interrupt <= 1'b0;
        end
    end

    // ########################################################################
    // Read ports
    // ########################################################################

    always_comb begin
        for (int p = 0; p < READ_PORTS; p++) begin
            case (read_addr[p])
                CREG_BADVADDR: read_data[p] = cp0.badvaddr;
                CREG_COUNT:    read_data[p] = cp0.count;
                CREG_COMPARE:  read_data[p] = cp0.compare;
                CREG_STATUS:   read_data[p] = cp0.status;
                CREG_CAUSE:    read_data[p] = cp0.cause;
                CREG_EPC:      read_data[p] = cp0.epc;
                CREG_CONFIG:   read_data[p] = cp0.config_;
                default:       read_data[p] = '0;
            endcase
        end
    end

    assign status = cp0.status;
    assign cause  = cp0.cause;
    assign epc    = cp0.epc;

    // ########################################################################
    // Next state
    // ########################################################################

    always_comb begin
        cp0_new       = cp0;
        compare_write = 1'b0;
        wdata         = '0;

        cp0_new.count = cp0.count + {31'd0, count_toggle};

        // HW5 shares its line with the timer as on a standard MIPS core
        cp0_new.cause.ip[7:2] = {timer_interrupt | hw_int[5], hw_int[4:0]};

        // Later lanes overwrite earlier ones
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            if (masked_retire[i].valid && masked_retire[i].cp0write) begin
                wdata.raw = masked_retire[i].data;
                case (masked_retire[i].dst)
                    CREG_COUNT:   cp0_new.count = wdata.raw;
                    CREG_COMPARE: begin
                        cp0_new.compare = wdata.raw;
                        compare_write   = 1'b1;
                    end
                    CREG_STATUS: begin
                        cp0_new.status.im  = wdata.status.im;
                        cp0_new.status.exl = wdata.status.exl;
                        cp0_new.status.ie  = wdata.status.ie;
                    end
                    CREG_CAUSE:   cp0_new.cause.ip[1:0] = wdata.cause.ip[1:0];
                    CREG_EPC:     cp0_new.epc = wdata.raw;
                    default: ;
                endcase
            end
        end

        if (exception.valid) begin
            // Nested exceptions keep the original return point
            if (!cp0.status.exl) begin
                cp0_new.cause.bd = exception.in_delay_slot;
                if (exception.in_delay_slot) begin
                    cp0_new.epc = exception.pc - 32'd4;     // Restart at the branch
                end else begin
                    cp0_new.epc = exception.pc;
                end
            end
            cp0_new.cause.exccode = exception.code;
            cp0_new.status.exl    = 1'b1;
            if (exception.code == CODE_ADEL || exception.code == CODE_ADES) begin
                cp0_new.badvaddr = exception.badvaddr;
            end
        end

        if (is_eret) begin
            if (cp0.status.erl) begin
                cp0_new.status.erl = 1'b0;
            end else begin
                cp0_new.status.exl = 1'b0;
            end
        end
    end

endmodule

/* rtl/exception_unit.sv */
`timescale 1ns/1ps

module exception_unit #(
    parameter int ISSUE_WIDTH = 2
) (
    input  core_pkg::retire_lane_t [ISSUE_WIDTH-1:0] retire,
    input  cp0_pkg::status_t                         status,
    input  cp0_pkg::cause_t                          cause,
    output core_pkg::exception_t                     exception,
    output logic                                     is_eret,
    output core_pkg::retire_lane_t [ISSUE_WIDTH-1:0] masked_retire
);
    import core_pkg::*;
    import cp0_pkg::*;

    logic int_pending;
    logic taken;

    // Build the exception record of one lane with the given code
    function automatic exception_t lane_exception(
        input retire_lane_t lane,
        input logic [4:0]   code
    );
        exception_t exc;
        exc.valid         = 1'b1;
        exc.code          = code;
        exc.in_delay_slot = lane.in_delay_slot;
        exc.pc            = lane.pc;
        exc.badvaddr      = lane.badvaddr;
        return exc;
    endfunction

    // Interrupts are only taken with IE set and outside exception level
    assign int_pending = status.ie & ~status.exl & (|(status.im & cause.ip));

    // ########################################################################
    // Oldest-first selection
    // ########################################################################

    always_comb begin
        exception     = '0;
        is_eret       = 1'b0;
        masked_retire = retire;
        taken         = 1'b0;

        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            if (!taken && retire[i].valid) begin
                if (i == 0 && int_pending) begin
                    // The interrupt replaces whatever lane 0 was doing
                    exception = lane_exception(retire[i], CODE_INT);
                    taken     = 1'b1;
                end else if (retire[i].exc_valid) begin
                    exception = lane_exception(retire[i], retire[i].exc_code);
                    taken     = 1'b1;
                end else if (retire[i].is_eret) begin
                    is_eret = 1'b1;
                    taken   = 1'b1;
                end
            end

            // The winner and everything younger must not touch CP0
            if (taken) begin
                masked_retire[i].cp0write = 1'b0;
            end
        end
    end

endmodule

/* rtl/cp0_pkg.sv */
package cp0_pkg;

    // ########################################################################
    // Register layouts
    // ########################################################################

    typedef logic [4:0] creg_addr_t;

    typedef struct packed {
        logic [15:0] zero_hi;
        logic [7:0]  im;            // Interrupt mask with one bit per IP line
        logic [4:0]  zero_lo;
        logic        erl;
        logic        exl;
        logic        ie;
    } status_t;

    typedef struct packed {
        logic        bd;            // Faulting instruction sat in a delay slot
        logic [14:0] zero_hi;
        logic [7:0]  ip;            // IP[7] timer, IP[6:2] hardware, IP[1:0] software
        logic        zero_mid;
        logic [4:0]  exccode;
        logic [1:0]  zero_lo;
    } cause_t;

    typedef struct packed {
        core_pkg::word_t badvaddr;
        core_pkg::word_t count;
        core_pkg::word_t compare;
        status_t         status;
        cause_t          cause;
        core_pkg::word_t epc;
        core_pkg::word_t config_;
    } cp0_regs_t;

    // A write word seen through the layout of its destination register
    typedef union packed {
        core_pkg::word_t raw;
        status_t         status;
        cause_t          cause;
    } cp0_wdata_u;

    // ########################################################################
    // Register numbers and exception codes
    // ########################################################################

    localparam creg_addr_t CREG_BADVADDR = 5'd8;
    localparam creg_addr_t CREG_COUNT    = 5'd9;
    localparam creg_addr_t CREG_COMPARE  = 5'd11;
    localparam creg_addr_t CREG_STATUS   = 5'd12;
    localparam creg_addr_t CREG_CAUSE    = 5'd13;
    localparam creg_addr_t CREG_EPC      = 5'd14;
    localparam creg_addr_t CREG_CONFIG   = 5'd16;

    localparam logic [4:0] CODE_INT  = 5'd0;
    localparam logic [4:0] CODE_ADEL = 5'd4;
    localparam logic [4:0] CODE_ADES = 5'd5;
    localparam logic [4:0] CODE_SYS  = 5'd8;
    localparam logic [4:0] CODE_BP   = 5'd9;
    localparam logic [4:0] CODE_RI   = 5'd10;
    localparam logic [4:0] CODE_OV   = 5'd12;

    // Only Config.M is set out of reset
    localparam cp0_regs_t CP0_INIT = '{
        badvaddr: '0,
        count:    '0,
        compare:  '0,
        status:   '0,
        cause:    '0,
        epc:      '0,
        config_:  32'h8000_0000
    };

endpackage

/* rtl/core_pkg.sv */
package core_pkg;

    // ########################################################################
    // Basic data types
    // ########################################################################

    typedef logic [31:0] word_t;

    // Entry point shared by every exception and interrupt
    localparam word_t EXC_VECTOR = 32'hBFC0_0380;

    // ########################################################################
    // Retire bundle
    // ########################################################################

    // One instruction leaving the pipeline where lane 0 is the oldest
    typedef struct packed {
        logic       valid;
        word_t      pc;
        logic       in_delay_slot;
        logic       cp0write;       // Writes data into CP0 register dst
        logic       is_eret;
        logic       exc_valid;      // Instruction raised a synchronous exception
        logic [4:0] exc_code;
        logic [4:0] dst;
        word_t      data;
        word_t      badvaddr;       // Faulting address for AdEL and AdES
    } retire_lane_t;

    // ########################################################################
    // Exception and redirect
    // ########################################################################

    // The exception picked for this cycle, at most one per cycle
    typedef struct packed {
        logic       valid;
        logic [4:0] code;
        logic       in_delay_slot;
        word_t      pc;
        word_t      badvaddr;
    } exception_t;

    // Fetch redirect towards the front end
    typedef struct packed {
        logic  valid;
        word_t pc;
    } redirect_t;

endpackage
